// ==== common/sh_config.svh ====
`ifndef SH_CONFIG_SVH
`define SH_CONFIG_SVH

`define SH_ADDR_W 32
`define SH_DATA_W 32

// On-chip register region and block bases, 16 bytes per block
`define SH_PERIPH_BASE 32'hFFFFFE00
`define SH_FRT_BASE (`SH_PERIPH_BASE + 32'h10)
`define SH_WDT_BASE (`SH_PERIPH_BASE + 32'h80)
`define SH_INTC_BASE (`SH_PERIPH_BASE + 32'hE0)

// FRT registers
`define SH_FRT_FRC 4'h0
`define SH_FRT_OCR 4'h4
`define SH_FRT_TCR 4'h8
`define SH_FRT_TSR 4'hC

// WDT registers
`define SH_WDT_WTCNT 4'h0
`define SH_WDT_WTCSR 4'h4

// INTC registers
`define SH_INTC_IPR 4'h0
`define SH_INTC_VCRFRT 4'h4
`define SH_INTC_VCRWDT 4'h8

// Prescaler, tap n divides by 2^(n+1)
`define SH_TAP_COUNT 13
`define SH_FRT_TAP_DIV8 2
`define SH_FRT_TAP_DIV32 4
`define SH_FRT_TAP_DIV128 6

`endif

// ==== common/busPkg.sv ====
package busPkg;

	`include "sh_config.svh"

	// One bus word each
	typedef logic [`SH_ADDR_W-1:0] addr_t;
	typedef logic [`SH_DATA_W-1:0] data_t;

	// Byte offset inside a 16-byte block
	typedef logic [3:0] regOfs_t;

	// Block hit by the current access
	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_FRT,
		SEL_WDT,
		SEL_INTC
	} periphSel_t;

	// Bit n pulses once every 2^(n+1) clocks
	typedef logic [`SH_TAP_COUNT-1:0] ceTaps_t;

endpackage

// ==== common/intPkg.sv ====
package intPkg;

	// Priority level, also used for the mask
	typedef logic [3:0] level_t;

	typedef logic [6:0] vector_t;

	// Declaration order is the tie-break order
	typedef enum logic {
		SRC_FRT,
		SRC_WDT
	} irqSrc_t;

endpackage

// ==== hdl/clockPrescaler.sv ====
`timescale 1ns/1ps
`include "sh_config.svh"

module clockPrescaler
	import busPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	output ceTaps_t ceTaps
);

	logic [`SH_TAP_COUNT-1:0] divCnt;
	logic [`SH_TAP_COUNT-1:0] tapHit;

	// Tap n fires when the low n+1 counter bits are all ones
	for (genvar n = 0; n < `SH_TAP_COUNT; n++) begin : genTap
		assign tapHit[n] = &divCnt[n:0];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt <= '0;
			ceTaps <= '0;
		end else begin
			divCnt <= divCnt + 1'b1;
			ceTaps <= tapHit;
		end
	end

endmodule

// ==== hdl/busFabric.sv ====
`timescale 1ns/1ps
`include "sh_config.svh"

module busFabric
	import busPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       req,
	input  logic       we,
	input  addr_t      addr,
	input  data_t      wdata,
	output logic       ack,
	output data_t      rdata,
	output logic       unmapped,
	output periphSel_t wrStb,
	output regOfs_t    regOfs,
	output data_t      wrData,
	input  data_t      frtRdata,
	input  data_t      wdtRdata,
	input  data_t      intcRdata
);

	localparam addr_t FRT_BASE = `SH_FRT_BASE;
	localparam addr_t WDT_BASE = `SH_WDT_BASE;
	localparam addr_t INTC_BASE = `SH_INTC_BASE;
	localparam int BLK_LSB = 4;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,
		ST_ACK
	} state_t;

	state_t state;
	periphSel_t sel;
	data_t selRdata;
	logic wrCycle;

	// Block decode on the upper address bits
	always_comb begin
		if (addr[`SH_ADDR_W-1:BLK_LSB] == FRT_BASE[`SH_ADDR_W-1:BLK_LSB])
			sel = SEL_FRT;
		else if (addr[`SH_ADDR_W-1:BLK_LSB] == WDT_BASE[`SH_ADDR_W-1:BLK_LSB])
			sel = SEL_WDT;
		else if (addr[`SH_ADDR_W-1:BLK_LSB] == INTC_BASE[`SH_ADDR_W-1:BLK_LSB])
			sel = SEL_INTC;
		else
			sel = SEL_NONE;
	end

	// Unmapped reads see zero
	assign selRdata = (sel == SEL_FRT)  ? frtRdata :
	                  (sel == SEL_WDT)  ? wdtRdata :
	                  (sel == SEL_INTC) ? intcRdata :
	                  '0;

	assign wrCycle = (state == ST_STROBE) && we;
	assign wrStb = wrCycle ? sel : SEL_NONE;
	assign wrData = wrCycle ? wdata : '0;
	assign regOfs = addr[BLK_LSB-1:0];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			ack <= 1'b0;
			unmapped <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Drop ack one cycle after req went low
					if (ack)
						ack <= 1'b0;
					else if (req)
						state <= ST_STROBE;
				end
				ST_STROBE: state <= ST_ACK;
				ST_ACK: begin
					if (!ack) begin
						ack <= 1'b1;
						unmapped <= (sel == SEL_NONE);
					end else if (!req) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read word held for the whole ack phase
	always_ff @(posedge CLK) begin
		if (state == ST_ACK && !ack)
			rdata <= selRdata;
	end

endmodule

// ==== frt/freeRunTimer.sv ====
`timescale 1ns/1ps
`include "sh_config.svh"

module freeRunTimer
	import busPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  ceTaps_t ceTaps,
	input  logic    wrStb,
	input  regOfs_t regOfs,
	input  data_t   wdata,
	output data_t   rdata,
	output logic    irq
);

	logic [15:0] frc;
	logic [15:0] nextFrc;
	logic [15:0] ocr;
	// TCR: [1:0] clock select, [2] run, [3] compare irq enable, [4] overflow irq enable
	logic [4:0] tcr;
	logic ocf;
	logic ovf;
	logic tick;

	always_comb begin
		case (tcr[1:0])
			2'd0: tick = ceTaps[`SH_FRT_TAP_DIV8];
			2'd1: tick = ceTaps[`SH_FRT_TAP_DIV32];
			2'd2: tick = ceTaps[`SH_FRT_TAP_DIV128];
			default: tick = 1'b0;
		endcase
	end

	assign nextFrc = frc + 16'd1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			frc <= '0;
			ocr <= 16'hFFFF;
			tcr <= '0;
			ocf <= 1'b0;
			ovf <= 1'b0;
		end else begin
			// Writing 0 clears a flag, a new event in the same cycle still sets it
			if (wrStb && regOfs == `SH_FRT_TSR) begin
				ocf <= ocf & wdata[0];
				ovf <= ovf & wdata[1];
			end
			if (wrStb && regOfs == `SH_FRT_FRC) begin
				frc <= wdata[15:0];
			end else if (tcr[2] && tick) begin
				frc <= nextFrc;
				if (nextFrc == ocr)
					ocf <= 1'b1;
				if (frc == 16'hFFFF)
					ovf <= 1'b1;
			end
			if (wrStb && regOfs == `SH_FRT_OCR)
				ocr <= wdata[15:0];
			if (wrStb && regOfs == `SH_FRT_TCR)
				tcr <= wdata[4:0];
		end
	end

	always_comb begin
		case (regOfs)
			`SH_FRT_FRC: rdata = data_t'(frc);
			`SH_FRT_OCR: rdata = data_t'(ocr);
			`SH_FRT_TCR: rdata = data_t'(tcr);
			`SH_FRT_TSR: rdata = data_t'({ovf, ocf});
			default: rdata = '0;
		endcase
	end

	assign irq = (ocf & tcr[3]) | (ovf & tcr[4]);

endmodule

// ==== wdt/watchdogTimer.sv ====
`timescale 1ns/1ps
`include "sh_config.svh"

module watchdogTimer
	import busPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  ceTaps_t ceTaps,
	input  logic    wrStb,
	input  regOfs_t regOfs,
	input  data_t   wdata,
	output data_t   rdata,
	output logic    irq,
	output logic    wdtOvfN
);

	logic [7:0] wtcnt;
	logic [2:0] cks;
	logic tme;
	// Set for watchdog mode, clear for interval mode
	logic wtMode;
	logic ovf;
	logic tick;

	// Dividers 2, 64, 128, 256, 512, 1024, 4096, 8192
	always_comb begin
		case (cks)
			3'd0: tick = ceTaps[0];
			3'd1: tick = ceTaps[5];
			3'd2: tick = ceTaps[6];
			3'd3: tick = ceTaps[7];
			3'd4: tick = ceTaps[8];
			3'd5: tick = ceTaps[9];
			3'd6: tick = ceTaps[11];
			default: tick = ceTaps[12];
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wtcnt <= '0;
			cks <= '0;
			tme <= 1'b0;
			wtMode <= 1'b0;
			ovf <= 1'b0;
		end else begin
			if (wrStb && regOfs == `SH_WDT_WTCSR) begin
				cks <= wdata[2:0];
				tme <= wdata[5];
				wtMode <= wdata[6];
				ovf <= ovf & wdata[7];
			end
			if (wrStb && regOfs == `SH_WDT_WTCNT) begin
				wtcnt <= wdata[7:0];
			end else if (tme && tick) begin
				wtcnt <= wtcnt + 8'd1;
				if (wtcnt == 8'hFF)
					ovf <= 1'b1;
			end
		end
	end

	always_comb begin
		case (regOfs)
			`SH_WDT_WTCNT: rdata = data_t'(wtcnt);
			`SH_WDT_WTCSR: rdata = data_t'({ovf, wtMode, tme, 2'b00, cks});
			default: rdata = '0;
		endcase
	end

	assign irq = ovf & ~wtMode;
	assign wdtOvfN = ~(ovf & wtMode);

endmodule

// ==== intc/interruptController.sv ====
`timescale 1ns/1ps
`include "sh_config.svh"

module interruptController
	import busPkg::*;
	import intPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    frtIrq,
	input  logic    wdtIrq,
	input  level_t  intMask,
	input  logic    wrStb,
	input  regOfs_t regOfs,
	input  data_t   wdata,
	output data_t   rdata,
	output logic    intReq,
	output level_t  intLevel,
	output vector_t intVector
);

	level_t frtPri;
	level_t wdtPri;
	vector_t frtVec;
	vector_t wdtVec;
	irqSrc_t winSrc;
	level_t winLvl;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			frtPri <= '0;
			wdtPri <= '0;
			frtVec <= '0;
			wdtVec <= '0;
		end else if (wrStb) begin
			case (regOfs)
				`SH_INTC_IPR: begin
					frtPri <= wdata[7:4];
					wdtPri <= wdata[3:0];
				end
				`SH_INTC_VCRFRT: frtVec <= wdata[6:0];
				`SH_INTC_VCRWDT: wdtVec <= wdata[6:0];
				default: ;
			endcase
		end
	end

	// WDT must be strictly higher, so FRT wins a tie
	always_comb begin
		winSrc = SRC_FRT;
		winLvl = '0;
		if (frtIrq)
			winLvl = frtPri;
		if (wdtIrq && wdtPri > winLvl) begin
			winSrc = SRC_WDT;
			winLvl = wdtPri;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			intReq <= 1'b0;
			intLevel <= '0;
			intVector <= '0;
		end else begin
			intReq <= (winLvl != '0) && (winLvl > intMask);
			intLevel <= winLvl;
			intVector <= (winSrc == SRC_WDT) ? wdtVec : frtVec;
		end
	end

	always_comb begin
		case (regOfs)
			`SH_INTC_IPR: rdata = data_t'({frtPri, wdtPri});
			`SH_INTC_VCRFRT: rdata = data_t'(frtVec);
			`SH_INTC_VCRWDT: rdata = data_t'(wdtVec);
			default: rdata = '0;
		endcase
	end

endmodule

// ==== hdl/periphSubsystem.sv ====
`timescale 1ns/1ps

module periphSubsystem
	import busPkg::*;
	import intPkg::*;
(
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    req,
	input  logic    we,
	input  addr_t   addr,
	input  data_t   wdata,
	output logic    ack,
	output data_t   rdata,
	output logic    unmapped,
	input  level_t  intMask,
	output logic    intReq,
	output level_t  intLevel,
	output vector_t intVector,
	output logic    wdtOvfN
);

	ceTaps_t ceTaps;
	periphSel_t wrStb;
	regOfs_t regOfs;
	data_t wrData;
	data_t frtRdata;
	data_t wdtRdata;
	data_t intcRdata;
	logic frtIrq;
	logic wdtIrq;

	clockPrescaler i_prescaler (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceTaps(ceTaps)
	);

	busFabric i_fabric (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.unmapped(unmapped),
		.wrStb(wrStb),
		.regOfs(regOfs),
		.wrData(wrData),
		.frtRdata(frtRdata),
		.wdtRdata(wdtRdata),
		.intcRdata(intcRdata)
	);

	freeRunTimer i_frt (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceTaps(ceTaps),
		.wrStb(wrStb == SEL_FRT),
		.regOfs(regOfs),
		.wdata(wrData),
		.rdata(frtRdata),
		.irq(frtIrq)
	);

	watchdogTimer i_wdt (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceTaps(ceTaps),
		.wrStb(wrStb == SEL_WDT),
		.regOfs(regOfs),
		.wdata(wrData),
		.rdata(wdtRdata),
		.irq(wdtIrq),
		.wdtOvfN(wdtOvfN)
	);

	interruptController i_intc (
		.CLK(CLK),
		.RST_N(RST_N),
		.frtIrq(frtIrq),
		.wdtIrq(wdtIrq),
		.intMask(intMask),
		.wrStb(wrStb == SEL_INTC),
		.regOfs(regOfs),
		.wdata(wrData),
		.rdata(intcRdata),
		.intReq(intReq),
		.intLevel(intLevel),
		.intVector(intVector)
	);

endmodule

// ==== bench/periphSubsystem_sva.sv ====
`timescale 1ns/1ps

module periphSubsystemSva
	import intPkg::*;
(
	input logic   CLK,
	input logic   RST_N,
	input logic   req,
	input logic   ack,
	input logic   intReq,
	input level_t intLevel,
	input level_t intMask
);

	// ack rises two cycles after the edge that first samples req
	ackRiseTiming: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(ack) |-> $past(req, 3) && !$past(req, 4))
		else $error("ack rose at the wrong distance from req");

	// Held req keeps the transfer open
	ackHeld: assert property (@(posedge CLK) disable iff (!RST_N)
		ack && req |=> ack)
		else $error("ack dropped while req was still high");

	// intReq was computed against the mask of the cycle before
	intAboveMask: assert property (@(posedge CLK) disable iff (!RST_N)
		intReq |-> intLevel > $past(intMask))
		else $error("intReq high with a level not above the mask");

endmodule

bind busFabric periphSubsystemSva i_handshakeSva (
	.CLK(CLK),
	.RST_N(RST_N),
	.req(req),
	.ack(ack),
	.intReq(1'b0),
	.intLevel(4'h0),
	.intMask(4'h0)
);

bind interruptController periphSubsystemSva i_intSva (
	.CLK(CLK),
	.RST_N(RST_N),
	.req(1'b0),
	.ack(1'b0),
	.intReq(intReq),
	.intLevel(intLevel),
	.intMask(intMask)
);

// ==== bench/tb_periphSubsystem.sv ====
`timescale 1ns/1ps

module tb_periphSubsystem
	import busPkg::*;
	import intPkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int BUS_LIMIT = 20;

	localparam int OP_W = 0;
	localparam int OP_R = 1;
	localparam int OP_IRQ = 2;
	localparam int OP_NOIRQ = 3;
	localparam int OP_OVF = 4;
	localparam int OP_MASK = 5;

	logic CLK;
	logic RST_N;
	logic req;
	logic we;
	addr_t addr;
	data_t wdata;
	logic ack;
	data_t rdata;
	logic unmapped;
	level_t intMask;
	logic intReq;
	level_t intLevel;
	vector_t intVector;
	logic wdtOvfN;

	// One entry per case line
	int opQ[$];
	addr_t addrQ[$];
	data_t dataQ[$];
	data_t expQ[$];
	int limitQ[$];

	int timeoutCycles;
	bit casesLoaded;
	int failCount;
	int passCount;

	periphSubsystem i_dut (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.unmapped(unmapped),
		.intMask(intMask),
		.intReq(intReq),
		.intLevel(intLevel),
		.intVector(intVector),
		.wdtOvfN(wdtOvfN)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	function automatic int opCode(input logic [63:0] name);
		case (name)
			64'("W"): return OP_W;
			64'("R"): return OP_R;
			64'("IRQ"): return OP_IRQ;
			64'("NOIRQ"): return OP_NOIRQ;
			64'("OVF"): return OP_OVF;
			64'("MASK"): return OP_MASK;
			default: return -1;
		endcase
	endfunction

	function automatic string opName(input int code);
		case (code)
			OP_W: return "W";
			OP_R: return "R";
			OP_IRQ: return "IRQ";
			OP_NOIRQ: return "NOIRQ";
			OP_OVF: return "OVF";
			default: return "MASK";
		endcase
	endfunction

	// Bus steps get a fixed margin, wait steps their own limit
	task automatic loadCases();
		int fd;
		int n;
		int code;
		int lim;
		logic [63:0] token;
		logic [1023:0] rest;
		addr_t a;
		data_t d;
		data_t e;
		fd = $fopen("bench/periph_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file bench/periph_cases.txt");
			failCount++;
			return;
		end
		while ($fscanf(fd, "%s", token) == 1) begin
			if (token == 64'("#")) begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%h %h %h %d", a, d, e, lim);
				code = opCode(token);
				if (n != 4 || code < 0) begin
					$display("Case file line %0d is malformed", opQ.size());
					failCount++;
				end else begin
					opQ.push_back(code);
					addrQ.push_back(a);
					dataQ.push_back(d);
					expQ.push_back(e);
					limitQ.push_back(lim);
					timeoutCycles += (code == OP_W || code == OP_R) ? BUS_LIMIT : lim;
				end
			end
		end
		$fclose(fd);
	endtask

	// Four-phase transfer, inputs change 1 ns after the edge
	task automatic busTransfer(input logic isWrite, input addr_t a, input data_t d,
			output data_t rd, output logic unm, output bit done);
		int cnt;
		done = 1'b0;
		rd = '0;
		unm = 1'b0;
		@(posedge CLK);
		#1;
		req = 1'b1;
		we = isWrite;
		addr = a;
		wdata = d;
		cnt = 0;
		while (!ack && cnt < BUS_LIMIT) begin
			@(posedge CLK);
			#1;
			cnt++;
		end
		if (!ack) begin
			$display("Access to %h got no ack within %0d cycles", a, BUS_LIMIT);
			req = 1'b0;
			return;
		end
		// Keep req up one more cycle, the transfer must stay open
		@(posedge CLK);
		#1;
		if (!ack) begin
			$display("ack fell for %h while req was still held high", a);
			req = 1'b0;
			return;
		end
		rd = rdata;
		unm = unmapped;
		req = 1'b0;
		cnt = 0;
		while (ack && cnt < BUS_LIMIT) begin
			@(posedge CLK);
			#1;
			cnt++;
		end
		if (ack) begin
			$display("ack stayed high for %0d cycles after req dropped", BUS_LIMIT);
			return;
		end
		we = 1'b0;
		addr = '0;
		wdata = '0;
		done = 1'b1;
	endtask

	task automatic runCase(input int idx, output bit ok);
		addr_t a;
		data_t d;
		data_t e;
		data_t rd;
		logic unm;
		bit done;
		int lim;
		int cnt;
		a = addrQ[idx];
		d = dataQ[idx];
		e = expQ[idx];
		lim = limitQ[idx];
		ok = 1'b1;
		case (opQ[idx])
			OP_W: begin
				busTransfer(1'b1, a, d, rd, unm, done);
				if (!done)
					ok = 1'b0;
				else
					assert (unm === e[0]) else begin
						$display("[FAIL] %0t: write to %h gave unmapped %b, expected %b",
							$time, a, unm, e[0]);
						ok = 1'b0;
					end
			end
			OP_R: begin
				busTransfer(1'b0, a, '0, rd, unm, done);
				if (!done) begin
					ok = 1'b0;
				end else begin
					assert (rd === e) else begin
						$display("[FAIL] %0t: read of %h gave %h, expected %h",
							$time, a, rd, e);
						ok = 1'b0;
					end
					assert (unm === d[0]) else begin
						$display("[FAIL] %0t: read of %h gave unmapped %b, expected %b",
							$time, a, unm, d[0]);
						ok = 1'b0;
					end
				end
			end
			OP_IRQ: begin
				cnt = 0;
				while (!intReq && cnt < lim) begin
					@(posedge CLK);
					#1;
					cnt++;
				end
				if (!intReq) begin
					$display("intReq did not rise within %0d cycles", lim);
					ok = 1'b0;
				end else begin
					assert (intLevel === d[3:0] && intVector === e[6:0]) else begin
						$display("[FAIL] %0t: level %h vector %h, expected %h and %h",
							$time, intLevel, intVector, d[3:0], e[6:0]);
						ok = 1'b0;
					end
				end
			end
			OP_NOIRQ: begin
				repeat (lim) @(posedge CLK);
				#1;
				assert (intReq === 1'b0) else begin
					$display("[FAIL] %0t: intReq high with level %h and mask %h",
						$time, intLevel, intMask);
					ok = 1'b0;
				end
			end
			OP_OVF: begin
				if (e[0] == 1'b0) begin
					cnt = 0;
					while (wdtOvfN && cnt < lim) begin
						@(posedge CLK);
						#1;
						cnt++;
					end
					if (wdtOvfN) begin
						$display("wdtOvfN did not go low within %0d cycles", lim);
						ok = 1'b0;
					end
				end else begin
					repeat (lim) @(posedge CLK);
					#1;
					assert (wdtOvfN === 1'b1) else begin
						$display("[FAIL] %0t: wdtOvfN low, expected high", $time);
						ok = 1'b0;
					end
				end
			end
			default: begin
				@(posedge CLK);
				#1;
				intMask = d[3:0];
			end
		endcase
	endtask

	// Watchdog on the total length of the case list
	initial begin
		wait (casesLoaded);
		repeat (timeoutCycles) @(posedge CLK);
		$display("Run did not finish within %0d cycles", timeoutCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int idx;
		bit ok;
		RST_N = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		intMask = '0;
		failCount = 0;
		passCount = 0;
		timeoutCycles = 0;
		casesLoaded = 1'b0;
		loadCases();
		if (failCount == 0)
			casesLoaded = 1'b1;
		repeat (3) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		if (casesLoaded) begin
			for (idx = 0; idx < opQ.size(); idx++) begin
				runCase(idx, ok);
				if (ok)
					passCount++;
				else
					failCount++;
				$display("test %0d %s %h: %s", idx, opName(opQ[idx]), addrQ[idx],
					ok ? "ok" : "failed");
			end
		end
		$display("%0d tests passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== bench/periph_cases.txt ====
# op addr data expect limit, numbers in hex except limit in cycles
# W data=wdata expect=unmapped, R data=unmapped expect=rdata, IRQ data=level expect=vector
W FFFFFE14 1234ABCD 0 0
R FFFFFE14 0 0000ABCD 0
W FFFFFE18 FFFFFF1B 0 0
R FFFFFE18 0 0000001B 0
W FFFFFE84 FFFFFF5B 0 0
R FFFFFE84 0 00000043 0
W FFFFFEE0 12345653 0 0
R FFFFFEE0 0 00000053 0
W FFFFFEE4 000000C4 0 0
R FFFFFEE4 0 00000044 0
W FFFFFEE8 FFFFFF95 0 0
R FFFFFEE8 0 00000015 0
R FFFFFE00 1 00000000 0
R FFFFFE14 0 0000ABCD 0
W FFFFFE40 12345678 1 0
W 00001000 FFFFFFFF 1 0
R FFFFFE18 0 0000001B 0
R 00000010 1 00000000 0
W FFFFFE14 00000004 0 0
W FFFFFE10 00000000 0 0
W FFFFFE18 0000000C 0 0
IRQ 00000000 5 44 60
W FFFFFE1C 00000000 0 0
NOIRQ 00000000 0 0 5
MASK 00000000 F 0 0
W FFFFFE80 000000F0 0 0
W FFFFFE84 00000020 0 0
W FFFFFE10 00000000 0 0
NOIRQ 00000000 0 0 80
R FFFFFE1C 0 00000001 0
R FFFFFE84 0 000000A0 0
MASK 00000000 0 0 0
IRQ 00000000 5 44 5
W FFFFFEE0 00000037 0 0
IRQ 00000000 7 15 5
W FFFFFEE0 00000066 0 0
IRQ 00000000 6 44 5
MASK 00000000 6 0 0
NOIRQ 00000000 0 0 5
MASK 00000000 7 0 0
NOIRQ 00000000 0 0 5
MASK 00000000 5 0 0
IRQ 00000000 6 44 5
W FFFFFE1C 00000000 0 0
IRQ 00000000 6 15 5
W FFFFFE84 00000000 0 0
NOIRQ 00000000 0 0 5
W FFFFFE80 000000F0 0 0
W FFFFFE84 00000060 0 0
OVF 00000000 0 0 80
NOIRQ 00000000 0 0 5
R FFFFFE84 0 000000E0 0
W FFFFFE84 00000000 0 0
OVF 00000000 0 1 5
W FFFFFE80 000000F0 0 0
W FFFFFE84 00000020 0 0
IRQ 00000000 6 15 80
OVF 00000000 0 1 10
W FFFFFE84 00000000 0 0
NOIRQ 00000000 0 0 5

// ==== vlog.f ====
+incdir+common
common/busPkg.sv
common/intPkg.sv
hdl/clockPrescaler.sv
hdl/busFabric.sv
frt/freeRunTimer.sv
wdt/watchdogTimer.sv
intc/interruptController.sv
hdl/periphSubsystem.sv
bench/periphSubsystem_sva.sv
bench/tb_periphSubsystem.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_periphSubsystem
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
